/* Makefile */
# Verilator simulation of the register block testbench

VERILATOR ?= verilator
TOP       ?= board_id_regs_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
verilog/axil_pkg.sv
verilog/regmap_pkg.sv
verilog/axil_write_channel.sv
verilog/axil_read_channel.sv
verilog/led_ctrl_regs.sv
verilog/id_read_decode.sv
verilog/board_id_regs.sv
verification/board_id_regs_tb.sv

/* verification/board_id_regs_tb.sv */
`timescale 1ns/1ps

module board_id_regs_tb;

	import axil_pkg::*;

	localparam int clk_period      = 10;
	localparam int num_tests       = 6;
	localparam int cycles_per_test = 200;

	// Board identity presented to the DUT
	localparam logic [63:0] hash_value  = 64'h0123_4567_89AB_CDEF;
	localparam logic [31:0] stamp_value = 32'h5F3A_1C20;

	logic                  S_AXI_ACLK;
	logic                  S_AXI_ARESETN;
	logic [63:0]           git_hash;
	logic [31:0]           timestamp;
	logic                  led;
	logic                  led3;
	logic [1:0]            led_sel;
	logic [addr_width-1:0] S_AXI_AWADDR;
	logic                  S_AXI_AWVALID;
	logic                  S_AXI_AWREADY;
	logic [31:0]           S_AXI_WDATA;
	logic [3:0]            S_AXI_WSTRB;
	logic                  S_AXI_WVALID;
	logic                  S_AXI_WREADY;
	logic [1:0]            S_AXI_BRESP;
	logic                  S_AXI_BVALID;
	logic                  S_AXI_BREADY;
	logic [addr_width-1:0] S_AXI_ARADDR;
	logic                  S_AXI_ARVALID;
	logic                  S_AXI_ARREADY;
	logic [31:0]           S_AXI_RDATA;
	logic [1:0]            S_AXI_RRESP;
	logic                  S_AXI_RVALID;
	logic                  S_AXI_RREADY;

	// Reference model of the writable words
	logic [31:0] ctrl_model;
	logic [31:0] scratch_model [8];
	logic [31:0] exp_rdata;
	logic [1:0]  exp_led_sel;

	// High from the start of a write until its B handshake
	logic        write_busy;

	string       test_name;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          failed_tests;

	board_id_regs i_board_id_regs (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// ------------------------------
	// Reporting and reference model
	// ------------------------------

	task automatic report_failure(input string what);
		test_errors++;
		total_errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic report_mismatch(input logic [31:0] expected, input logic [31:0] actual);
		test_errors++;
		total_errors++;
		$display("mismatch %s expected %08h actual %08h", test_name, expected, actual);
	endtask

	// Byte lanes picked by strobe replace the old lanes
	function automatic logic [31:0] merge_strobed(input logic [31:0] old_word,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (data & mask);
	endfunction

	// Register map as the block is specified
	function automatic logic [31:0] expected_word(input int unsigned index);
		case (index)
			0: return hash_value[31:0];
			1: return hash_value[63:32];
			2: return stamp_value;
			3: return 32'hBAAF_DEEC;
			4: return 32'hDEAD_0666;
			5: return stamp_value;
			6: return {30'b0, led, led3};
			7: return ctrl_model;
			default:
			begin
				if (index >= 8 && index < 16)
					return scratch_model[3'(index - 8)];
				// Dropped scratch range
				return 32'h0;
			end
		endcase
	endfunction

	// ------------------------------
	// Concurrent checks
	// ------------------------------

	reset_idle: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
		(!S_AXI_AWREADY && !S_AXI_WREADY && !S_AXI_BVALID && !S_AXI_ARREADY
		&& !S_AXI_RVALID && led_sel == 2'b00 && S_AXI_RDATA == 32'h0))
		else report_failure("outputs not idle after reset");

	ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY == S_AXI_WREADY)
		else report_failure("AWREADY and WREADY differ");

	aw_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY |=> !S_AXI_AWREADY)
		else report_failure("AWREADY high for more than one cycle");

	b_after_write: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID) |=> S_AXI_BVALID)
		else report_failure("BVALID did not follow the write handshake");

	// Response held under back-pressure
	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_BVALID && !S_AXI_BREADY) |=> S_AXI_BVALID)
		else report_failure("BVALID dropped before BREADY");

	b_blocks_write: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> !S_AXI_AWREADY)
		else report_failure("second write accepted before B handshake");

	// OKAY is code 0
	b_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> S_AXI_BRESP == 2'b00)
		else report_failure("BRESP is not OKAY");

	ar_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_ARREADY |=> !S_AXI_ARREADY)
		else report_failure("ARREADY high for more than one cycle");

	r_after_read: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_ARREADY && S_AXI_ARVALID) |=> S_AXI_RVALID)
		else report_failure("RVALID did not follow ARREADY");

	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_RVALID && !S_AXI_RREADY) |=> (S_AXI_RVALID && $stable(S_AXI_RDATA)))
		else report_failure("read response changed before RREADY");

	r_blocks_read: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> !S_AXI_ARREADY)
		else report_failure("ARREADY high while a response is pending");

	r_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> S_AXI_RRESP == 2'b00)
		else report_failure("RRESP is not OKAY");

	r_data: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> S_AXI_RDATA == exp_rdata)
		else report_mismatch(exp_rdata, S_AXI_RDATA);

	// Selector settles by the time B is valid
	led_value: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(!write_busy || S_AXI_BVALID) |-> led_sel == exp_led_sel)
		else report_mismatch(32'(exp_led_sel), 32'(led_sel));

	// ------------------------------
	// Bus tasks
	// ------------------------------

	// Called and returning 1 ns after a rising edge
	task automatic write_word(input int unsigned index, input logic [31:0] data,
		input logic [3:0] strb, input int unsigned bdelay, input bit hold);
		write_busy = 1'b1;
		if (index == 7)
			ctrl_model = merge_strobed(ctrl_model, data, strb);
		else if (index >= 8 && index < 16)
			scratch_model[3'(index - 8)] = merge_strobed(scratch_model[3'(index - 8)], data, strb);
		exp_led_sel   = ctrl_model[1:0];
		S_AXI_AWADDR  = {5'(index), 2'b00};
		S_AXI_WDATA   = data;
		S_AXI_WSTRB   = strb;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID  = 1'b1;
		while (!S_AXI_AWREADY)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		// Handshake edge
		@(posedge S_AXI_ACLK);
		#1;
		// Hold keeps a second request waiting behind the B response
		if (!hold)
		begin
			S_AXI_AWVALID = 1'b0;
			S_AXI_WVALID  = 1'b0;
		end
		repeat (bdelay)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		S_AXI_BREADY = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		S_AXI_BREADY  = 1'b0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID  = 1'b0;
		write_busy    = 1'b0;
	endtask

	task automatic read_word(input int unsigned index, input int unsigned rdelay,
		input bit hold);
		exp_rdata     = expected_word(index);
		S_AXI_ARADDR  = {5'(index), 2'b00};
		S_AXI_ARVALID = 1'b1;
		while (!S_AXI_ARREADY)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		@(posedge S_AXI_ACLK);
		#1;
		if (!hold)
			S_AXI_ARVALID = 1'b0;
		repeat (rdelay)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		S_AXI_RREADY = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;
		S_AXI_RREADY  = 1'b0;
		S_AXI_ARVALID = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic finish_test();
		if (test_errors == 0)
			$display("%s: ok", test_name);
		else
		begin
			$display("%s: %0d errors", test_name, test_errors);
			failed_tests++;
		end
	endtask

	// ------------------------------
	// Watchdog and test sequence
	// ------------------------------

	initial
	begin
		#(num_tests * cycles_per_test * clk_period);
		$display("timeout: run did not end within %0d cycles", num_tests * cycles_per_test);
		$display("Checks failed");
		$finish;
	end

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		git_hash      = hash_value;
		timestamp     = stamp_value;
		led           = 1'b1;
		led3          = 1'b0;
		S_AXI_AWADDR  = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA   = '0;
		S_AXI_WSTRB   = '0;
		S_AXI_WVALID  = 1'b0;
		S_AXI_BREADY  = 1'b0;
		S_AXI_ARADDR  = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY  = 1'b0;
		ctrl_model    = '0;
		exp_rdata     = '0;
		exp_led_sel   = '0;
		write_busy    = 1'b0;
		test_errors   = 0;
		total_errors  = 0;
		tests_run     = 0;
		failed_tests  = 0;
		for (int i = 0; i < 8; i++)
			scratch_model[i] = '0;
		void'($urandom(50374));

		start_test("reset_state");
		repeat (5) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		for (int unsigned i = 0; i < 7; i++)
			read_word(i, 0, 1'b0);
		finish_test();

		start_test("handshake");
		write_word(8, $urandom(), 4'hf, 0, 1'b0);
		read_word(8, 0, 1'b0);
		read_word(3, 0, 1'b0);
		finish_test();

		start_test("scratch_writes");
		for (int round = 0; round < 2; round++)
		begin
			for (int unsigned i = 8; i < 16; i++)
				write_word(i, $urandom(), 4'($urandom()), 0, 1'b0);
			for (int unsigned i = 8; i < 16; i++)
				read_word(i, 0, 1'b0);
		end
		finish_test();

		start_test("led_control");
		for (int k = 0; k < 4; k++)
		begin
			// First pass writes every lane
			write_word(7, $urandom(), (k == 0) ? 4'hf : 4'($urandom()), 0, 1'b0);
			read_word(7, 0, 1'b0);
		end
		finish_test();

		start_test("ignored_writes");
		for (int unsigned i = 0; i < 7; i++)
			write_word(i, $urandom(), 4'hf, 0, 1'b0);
		for (int unsigned i = 16; i < 32; i++)
			write_word(i, $urandom(), 4'hf, 0, 1'b0);
		for (int unsigned i = 0; i < 32; i++)
			read_word(i, 0, 1'b0);
		finish_test();

		start_test("back_pressure");
		for (int unsigned i = 8; i < 12; i++)
		begin
			write_word(i, $urandom(), 4'hf, $urandom_range(6, 1), 1'b1);
			read_word(i, $urandom_range(6, 1), 1'b1);
		end
		read_word(2, $urandom_range(6, 1), 1'b1);
		finish_test();

		$display("tests %0d, tests with errors %0d, errors %0d",
			tests_run, failed_tests, total_errors);
		if (total_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* verilog/axil_pkg.sv */
package axil_pkg;

	// ------------------------------
	// Bus geometry
	// ------------------------------

	// Byte address, 32 words of 4 bytes
	localparam int unsigned addr_width = 7;

	// Data bus and its byte lanes
	localparam int unsigned data_width = 32;
	localparam int unsigned strb_width = data_width / 8;

	// Byte offset bits below the word index
	localparam int unsigned word_lsb    = 2;
	localparam int unsigned index_width = 5;

	// Response codes, only OKAY is ever issued
	localparam logic [1:0] resp_okay = 2'b00;

	// ------------------------------
	// Address views
	// ------------------------------

	// Same 7 bits seen as a byte address or as word index plus offset
	typedef union packed {
		logic [addr_width-1:0] raw;
		struct packed {
			logic [index_width-1:0] index;
			logic [word_lsb-1:0]    offset;
		} word;
	} axil_addr_u;

endpackage

/* verilog/axil_read_channel.sv */
`timescale 1ns/1ps

module axil_read_channel
(
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,

	// Read address channel
	input  axil_pkg::axil_addr_u                S_AXI_ARADDR,
	input  logic                                S_AXI_ARVALID,
	output logic                                S_AXI_ARREADY,

	// Read data channel
	output logic [axil_pkg::data_width-1:0]     S_AXI_RDATA,
	output logic [1:0]                          S_AXI_RRESP,
	output logic                                S_AXI_RVALID,
	input  logic                                S_AXI_RREADY,

	// Decode side
	output axil_pkg::axil_addr_u                rd_addr,
	input  logic [axil_pkg::data_width-1:0]     rd_word
);

	import axil_pkg::*;

	logic                  arready_q;
	logic                  rvalid_q;
	axil_addr_u            araddr_q;
	logic [data_width-1:0] rdata_q;

	// New address only when nothing is pending
	logic                  ar_accept;

	// Address handshake completes, decoded word is captured
	logic                  rd_fire;

	assign ar_accept = S_AXI_ARVALID & ~arready_q & ~rvalid_q;
	assign rd_fire   = S_AXI_ARVALID & arready_q;

	// ------------------------------
	// Address acceptance
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arready_q <= 1'b0;
		end
		else
		begin
			// One cycle pulse, held off under back-pressure
			arready_q <= ar_accept;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_accept)
		begin
			araddr_q <= S_AXI_ARADDR;
		end
	end

	// ------------------------------
	// Read response
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rvalid_q <= 1'b0;
			rdata_q  <= '0;
		end
		else if (rd_fire)
		begin
			rvalid_q <= 1'b1;
			rdata_q  <= rd_word;
		end
		else if (S_AXI_RREADY)
		begin
			// RDATA keeps its value, only valid drops
			rvalid_q <= 1'b0;
		end
	end

	assign S_AXI_ARREADY = arready_q;
	assign S_AXI_RVALID  = rvalid_q;
	assign S_AXI_RDATA   = rdata_q;
	assign S_AXI_RRESP   = resp_okay;
	assign rd_addr       = araddr_q;

endmodule

/* verilog/axil_write_channel.sv */
`timescale 1ns/1ps

module axil_write_channel
(
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,

	// Write address channel
	input  axil_pkg::axil_addr_u                S_AXI_AWADDR,
	input  logic                                S_AXI_AWVALID,
	output logic                                S_AXI_AWREADY,

	// Write data channel
	input  logic [axil_pkg::data_width-1:0]     S_AXI_WDATA,
	input  logic [axil_pkg::strb_width-1:0]     S_AXI_WSTRB,
	input  logic                                S_AXI_WVALID,
	output logic                                S_AXI_WREADY,

	// Write response channel
	output logic [1:0]                          S_AXI_BRESP,
	output logic                                S_AXI_BVALID,
	input  logic                                S_AXI_BREADY,

	// Register bank side
	output logic                                wr_en,
	output axil_pkg::axil_addr_u                wr_addr,
	output logic [axil_pkg::data_width-1:0]     wr_data,
	output logic [axil_pkg::strb_width-1:0]     wr_strb
);

	import axil_pkg::*;

	// Address and data accepted together, so one ready serves both
	logic       wr_ready_q;

	// Clear while a write is outstanding
	logic       aw_en;

	logic       bvalid_q;
	axil_addr_u awaddr_q;

	// Both channels present, no ready pulse yet, no write in flight
	logic       wr_accept;

	assign wr_accept = ~wr_ready_q & S_AXI_AWVALID & S_AXI_WVALID & aw_en;

	// ------------------------------
	// Ready pulse and outstanding flag
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ready_q <= 1'b0;
			aw_en      <= 1'b1;
		end
		else
		begin
			// Ready is high for exactly one cycle
			wr_ready_q <= wr_accept;

			if (wr_accept)
			begin
				aw_en <= 1'b0;
			end
			else if (bvalid_q && S_AXI_BREADY)
			begin
				// B taken, next write may start
				aw_en <= 1'b1;
			end
		end
	end

	// Address held for the register bank during the ready cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_accept)
		begin
			awaddr_q <= S_AXI_AWADDR;
		end
	end

	// Handshake completes while ready is high
	assign wr_en = wr_ready_q & S_AXI_AWVALID & S_AXI_WVALID;

	// ------------------------------
	// Write response
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			bvalid_q <= 1'b0;
		end
		else if (wr_en)
		begin
			// Response on the edge that commits the write
			bvalid_q <= 1'b1;
		end
		else if (S_AXI_BREADY)
		begin
			bvalid_q <= 1'b0;
		end
	end

	assign S_AXI_AWREADY = wr_ready_q;
	assign S_AXI_WREADY  = wr_ready_q;
	assign S_AXI_BVALID  = bvalid_q;
	assign S_AXI_BRESP   = resp_okay;

	// Data and strobes are still on the bus during the ready cycle
	assign wr_addr = awaddr_q;
	assign wr_data = S_AXI_WDATA;
	assign wr_strb = S_AXI_WSTRB;

endmodule

/* verilog/board_id_regs.sv */
`timescale 1ns/1ps

module board_id_regs
(
	// Board identification and LEDs
	input  logic [2*axil_pkg::data_width-1:0]    git_hash,
	input  logic [axil_pkg::data_width-1:0]      timestamp,
	input  logic                                 led,
	input  logic                                 led3,
	output logic [regmap_pkg::led_sel_width-1:0] led_sel,

	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,

	// AXI4-Lite write side
	input  logic [axil_pkg::addr_width-1:0]      S_AXI_AWADDR,
	input  logic                                 S_AXI_AWVALID,
	output logic                                 S_AXI_AWREADY,
	input  logic [axil_pkg::data_width-1:0]      S_AXI_WDATA,
	input  logic [axil_pkg::strb_width-1:0]      S_AXI_WSTRB,
	input  logic                                 S_AXI_WVALID,
	output logic                                 S_AXI_WREADY,
	output logic [1:0]                           S_AXI_BRESP,
	output logic                                 S_AXI_BVALID,
	input  logic                                 S_AXI_BREADY,

	// AXI4-Lite read side
	input  logic [axil_pkg::addr_width-1:0]      S_AXI_ARADDR,
	input  logic                                 S_AXI_ARVALID,
	output logic                                 S_AXI_ARREADY,
	output logic [axil_pkg::data_width-1:0]      S_AXI_RDATA,
	output logic [1:0]                           S_AXI_RRESP,
	output logic                                 S_AXI_RVALID,
	input  logic                                 S_AXI_RREADY
);

	import axil_pkg::*;
	import regmap_pkg::*;

	// ------------------------------
	// Internal wiring
	// ------------------------------

	// Write channel to register bank
	logic                                 wr_en;
	axil_addr_u                           wr_addr;
	logic [data_width-1:0]                wr_data;
	logic [strb_width-1:0]                wr_strb;

	// Read channel and decode
	axil_addr_u                           rd_addr;
	logic [data_width-1:0]                rd_word;

	// Register bank to decode
	logic [data_width-1:0]                led_ctrl_word;
	logic [scratch_count*data_width-1:0]  scratch_words;

	axil_write_channel i_axil_write_channel
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb)
	);

	axil_read_channel i_axil_read_channel
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.rd_addr       (rd_addr),
		.rd_word       (rd_word)
	);

	// Storage for control and scratch words
	led_ctrl_regs i_led_ctrl_regs
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb),
		.led_ctrl_word (led_ctrl_word),
		.scratch_words (scratch_words),
		.led_sel       (led_sel)
	);

	// Zero latency select into the read channel
	id_read_decode i_id_read_decode
	(
		.rd_addr       (rd_addr),
		.git_hash      (git_hash),
		.timestamp     (timestamp),
		.led           (led),
		.led3          (led3),
		.led_ctrl_word (led_ctrl_word),
		.scratch_words (scratch_words),
		.rd_word       (rd_word)
	);

endmodule

/* verilog/id_read_decode.sv */
`timescale 1ns/1ps

module id_read_decode
(
	// Latched read address
	input  axil_pkg::axil_addr_u                        rd_addr,

	// Board identification
	input  logic [2*axil_pkg::data_width-1:0]           git_hash,
	input  logic [axil_pkg::data_width-1:0]             timestamp,
	input  logic                                        led,
	input  logic                                        led3,

	// Stored registers
	input  logic [axil_pkg::data_width-1:0]             led_ctrl_word,
	input  logic [regmap_pkg::scratch_count*axil_pkg::data_width-1:0] scratch_words,

	output logic [axil_pkg::data_width-1:0]             rd_word
);

	import axil_pkg::*;
	import regmap_pkg::*;

	// ------------------------------
	// Word select
	// ------------------------------

	always_comb
	begin
		// Unmapped words read as zero
		rd_word = '0;
		case (rd_addr.word.index)
			index_width'(reg_hash_lo):        rd_word = git_hash[data_width-1:0];
			index_width'(reg_hash_hi):        rd_word = git_hash[2*data_width-1:data_width];
			index_width'(reg_timestamp):      rd_word = timestamp;
			index_width'(reg_magic_a):        rd_word = magic_a_value;
			index_width'(reg_magic_b):        rd_word = magic_b_value;
			index_width'(reg_timestamp_copy): rd_word = timestamp;
			// Live LED inputs
			index_width'(reg_led_status):     rd_word = {{(data_width-2){1'b0}}, led, led3};
			index_width'(reg_led_ctrl):       rd_word = led_ctrl_word;
			default:
			begin
				// Scratch range, everything above stays zero
				for (int i = 0; i < scratch_count; i++)
				begin
					if (rd_addr.word.index == index_width'(reg_scratch_base + i))
					begin
						rd_word = scratch_words[i*data_width +: data_width];
					end
				end
			end
		endcase
	end

endmodule

/* verilog/led_ctrl_regs.sv */
`timescale 1ns/1ps

module led_ctrl_regs
(
	input  logic                                        S_AXI_ACLK,
	input  logic                                        S_AXI_ARESETN,

	// Committed write from the write channel
	input  logic                                        wr_en,
	input  axil_pkg::axil_addr_u                        wr_addr,
	input  logic [axil_pkg::data_width-1:0]             wr_data,
	input  logic [axil_pkg::strb_width-1:0]             wr_strb,

	// Stored words toward the read decode
	output logic [axil_pkg::data_width-1:0]             led_ctrl_word,
	output logic [regmap_pkg::scratch_count*axil_pkg::data_width-1:0] scratch_words,

	// LED selector toward the board
	output logic [regmap_pkg::led_sel_width-1:0]        led_sel
);

	import axil_pkg::*;
	import regmap_pkg::*;

	// Merge strobed byte lanes into the old word
	function automatic logic [data_width-1:0] merge_bytes(
		input logic [data_width-1:0] old_word,
		input logic [data_width-1:0] new_word,
		input logic [strb_width-1:0] strb
	);
		logic [data_width-1:0] result;
		result = old_word;
		for (int b = 0; b < strb_width; b++)
		begin
			if (strb[b])
			begin
				result[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return result;
	endfunction

	logic [data_width-1:0]                    led_ctrl_q;
	logic [scratch_count-1:0][data_width-1:0] scratch_q;

	// ------------------------------
	// LED control word
	// ------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			led_ctrl_q <= '0;
		end
		else if (wr_en && wr_addr.word.index == index_width'(reg_led_ctrl))
		begin
			led_ctrl_q <= merge_bytes(led_ctrl_q, wr_data, wr_strb);
		end
	end

	// ------------------------------
	// Scratch words
	// ------------------------------

	// Indices outside the scratch range never match
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			scratch_q <= '0;
		end
		else
		begin
			for (int i = 0; i < scratch_count; i++)
			begin
				if (wr_en && wr_addr.word.index == index_width'(reg_scratch_base + i))
				begin
					scratch_q[i] <= merge_bytes(scratch_q[i], wr_data, wr_strb);
				end
			end
		end
	end

	assign led_ctrl_word = led_ctrl_q;

	// Word i sits at bits i*32 upward
	assign scratch_words = scratch_q;

	// Selector follows the stored low bits
	assign led_sel = led_ctrl_q[led_sel_width-1:0];

endmodule

/* verilog/regmap_pkg.sv */
package regmap_pkg;

	// ------------------------------
	// Word indices
	// ------------------------------

	// Read-only identification words
	localparam int unsigned reg_hash_lo        = 0;
	localparam int unsigned reg_hash_hi        = 1;
	localparam int unsigned reg_timestamp      = 2;
	localparam int unsigned reg_magic_a        = 3;
	localparam int unsigned reg_magic_b        = 4;
	localparam int unsigned reg_timestamp_copy = 5;

	// LED status, led in bit 1 and led3 in bit 0
	localparam int unsigned reg_led_status = 6;

	// Writable LED control word
	localparam int unsigned reg_led_ctrl = 7;

	// First of the scratch words
	localparam int unsigned reg_scratch_base = 8;

	// ------------------------------
	// Contents and sizes
	// ------------------------------

	// Number of scratch words above the control word
	localparam int unsigned scratch_count = 8;

	// Fixed patterns that let software find the block
	localparam logic [31:0] magic_a_value = 32'hBAAF_DEEC;
	localparam logic [31:0] magic_b_value = 32'hDEAD_0666;

	// LED selector bits taken from the control word
	localparam int unsigned led_sel_width = 2;

endpackage
